// ==== project.f ====
+incdir+include
rtl/dsi_pkg.sv
rtl/lcd_power_seq.sv
rtl/video_timing.sv
rtl/smpte_pattern.sv
rtl/dsi_framer.sv
rtl/dsi_pattern_top.sv
tests/dsi_pattern_checker.sv
tests/dsi_pattern_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vdsi_pattern_tb
SRCS = $(wildcard rtl/*.sv tests/*.sv include/*.svh) project.f

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module dsi_pattern_tb -o Vdsi_pattern_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/dsi_pattern_tb.sv ====
`timescale 1ns/1ps
`include "dsi_macros.svh"

module dsi_pattern_tb;

	// Small panel so that a full frame takes 480 cycles
	localparam int MS_CYCLES = 4;
	localparam int HALF_WIDTH = 16;
	localparam int HEIGHT = 16;
	localparam int V_BACK = 2;
	localparam int V_TOTAL = 20;
	localparam int LINE_WORDS = 24;
	localparam int H_BLANK = 10;

	localparam int PAY_WORDS = HALF_WIDTH * 3 / 8;
	localparam int FRAME_WORDS = LINE_WORDS * V_TOTAL;
	localparam int FULL_WIDTH = 2 * HALF_WIDTH;
	localparam int UPPER_LAST = 12;
	localparam int PIX_LINES = 5;

	// Reset, 26 ms power-up and three frames come to about 1560 cycles
	localparam int TIMEOUT_CYCLES = 3000;

	logic               clk;
	logic               i_rst_n;
	logic               o_lcd_en_vcc;
	logic               o_lcd_en_vsp;
	logic               o_lcd_en_vsn;
	logic               o_lcd_reset;
	logic               o_lp_en;
	logic               o_hs_en;
	dsi_pkg::dsi_word_t link_a;
	dsi_pkg::dsi_word_t link_b;

	int          err_count;
	int          cycle_count;
	logic [31:0] rand_state;

	dsi_pattern_top #(
		.MS_CYCLES(MS_CYCLES),
		.HALF_WIDTH(HALF_WIDTH),
		.HEIGHT(HEIGHT),
		.V_BACK(V_BACK),
		.V_TOTAL(V_TOTAL),
		.H_BLANK(H_BLANK),
		.LINE_WORDS(LINE_WORDS)
	) dsi_pattern_top_inst (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.o_lcd_en_vcc(o_lcd_en_vcc),
		.o_lcd_en_vsp(o_lcd_en_vsp),
		.o_lcd_en_vsn(o_lcd_en_vsn),
		.o_lcd_reset(o_lcd_reset),
		.o_lp_en(o_lp_en),
		.o_hs_en(o_hs_en),
		.o_link_a(link_a),
		.o_link_b(link_b)
	);

	bind dsi_pattern_top dsi_pattern_checker checker_inst (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_lcd_en_vcc(o_lcd_en_vcc),
		.i_lcd_reset(o_lcd_reset),
		.i_lp_en(o_lp_en),
		.i_hs_en(o_hs_en),
		.i_link_a(o_link_a),
		.i_link_b(o_link_b)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	//////////////////////////////
	// Helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [23:0] upper_bar(input int i);
		case (i)
			0: return 24'hc0c0c0;
			1: return 24'hc0c000;
			2: return 24'h00c0c0;
			3: return 24'h00c000;
			4: return 24'hc000c0;
			5: return 24'hc00000;
			default: return 24'h0000c0;
		endcase
	endfunction

	function automatic logic [23:0] lower_bar(input int i);
		case (i)
			0: return 24'h00214c;
			1: return 24'hffffff;
			2: return 24'h32006a;
			3: return 24'h1d1d1d;
			4: return 24'h131313;
			default: return 24'h090909;
		endcase
	endfunction

	// Reference colour of pixel x on row y, full panel width
	function automatic logic [23:0] expected_colour(input int x, input int y);
		int bar;
		bar = 0;
		if (x == 0 || y == 0 || x == FULL_WIDTH - 1 || y == HEIGHT - 1)
			return 24'hffffff;
		if (x == y || x == HEIGHT - 1 - y)
			return 24'hffffff;
		if (y <= UPPER_LAST) begin
			while (bar < 6 && x >= (FULL_WIDTH * (bar + 1)) / 7)
				bar++;
			return upper_bar(bar);
		end
		while (bar < 5 && x >= (FULL_WIDTH * (bar + 1)) / 6)
			bar++;
		return lower_bar(bar);
	endfunction

	task automatic log_fail(input string msg);
		err_count++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic compare_byte(input string name, input int line, input int word,
		input int idx, input logic [7:0] got, input logic [7:0] want);
		if (got != want)
			log_fail($sformatf("link %s line %0d word %0d byte %0d is %02h, expected %02h",
				name, line, word, idx, got, want));
	endtask

	// Sample point and drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_rise(input string name, input int rise, input int thr);
		if (rise < thr || rise > thr + 2)
			log_fail($sformatf("%s rose at cycle %0d, threshold %0d", name, rise, thr));
	endtask

	//////////////////////////////
	// Tests

	task automatic check_power_sequence();
		int n;
		int rise_vcc;
		int rise_vsp;
		int rise_vsn;
		int rise_rst;
		int rise_lp;
		int rise_hs;
		logic lp_prev;
		n = 0;
		rise_vcc = -1;
		rise_vsp = -1;
		rise_vsn = -1;
		rise_rst = -1;
		rise_lp = -1;
		rise_hs = -1;
		if (o_lcd_en_vcc || o_lcd_en_vsp || o_lcd_en_vsn || o_lcd_reset || o_lp_en || o_hs_en)
			log_fail("power outputs not all low after reset");
		lp_prev = o_lp_en;
		while (!o_hs_en) begin
			next_cycle();
			n++;
			if (o_lcd_en_vcc && rise_vcc < 0)
				rise_vcc = n;
			if (o_lcd_en_vsp && rise_vsp < 0)
				rise_vsp = n;
			if (o_lcd_en_vsn && rise_vsn < 0)
				rise_vsn = n;
			if (o_lcd_reset && rise_rst < 0)
				rise_rst = n;
			if (o_lp_en && rise_lp < 0)
				rise_lp = n;
			if (o_hs_en) begin
				rise_hs = n;
				if (o_lp_en || !lp_prev)
					log_fail("lp_en did not fall in the cycle hs_en rose");
			end
			lp_prev = o_lp_en;
		end
		check_rise("vcc", rise_vcc, MS_CYCLES);
		check_rise("vsp", rise_vsp, 2 * MS_CYCLES);
		check_rise("vsn", rise_vsn, 3 * MS_CYCLES);
		check_rise("lcd_reset", rise_rst, 6 * MS_CYCLES);
		check_rise("lp_en", rise_lp, 3 * MS_CYCLES);
		check_rise("hs_en", rise_hs, 26 * MS_CYCLES);
		if (!(rise_vcc < rise_vsp && rise_vsp < rise_vsn && rise_vsn < rise_rst))
			log_fail("supplies and panel reset rose out of order");
		if (rise_lp < rise_vsn)
			log_fail("lp_en rose before vsn");
	endtask

	task automatic check_idle_links();
		while (!o_hs_en) begin
			if (link_a != '0 || link_b != '0)
				log_fail("link data before hs_en rose");
			next_cycle();
		end
	endtask

	task automatic find_first_vss();
		while (link_a[0] != `DSI_ID_VSS)
			next_cycle();
	endtask

	// Walks one frame starting at its VSS word
	task automatic check_line_headers(input bit first_frame);
		int line;
		int word;
		int idx;
		bit skip;
		logic [7:0] want;
		for (int pos = 0; pos < FRAME_WORDS; pos++) begin
			line = pos / LINE_WORDS;
			word = pos % LINE_WORDS;
			idx = 0;
			skip = 1'b0;
			want = `DSI_ID_BLANK;
			if (word == 0) begin
				want = (line == 0) ? `DSI_ID_VSS : `DSI_ID_HSS;
			end else if (word == 1) begin
				skip = 1'b1;
			end else if (line == 0 && word == 8) begin
				want = first_frame ? `DSI_ID_DCS_SHORT : `DSI_ID_BLANK;
			end else if (line >= V_BACK && line < V_BACK + HEIGHT) begin
				if (word == H_BLANK - 1) begin
					idx = 4;
					want = `DSI_ID_RGB24;
				end else if (word >= H_BLANK && word <= H_BLANK + PAY_WORDS) begin
					// Pixel payload and the word closing it
					skip = 1'b1;
				end
			end
			if (!skip) begin
				compare_byte("A", line, word, idx, link_a[idx], want);
				compare_byte("B", line, word, idx, link_b[idx], want);
			end
			next_cycle();
		end
	endtask

	task automatic check_frame_repeat();
		if (link_a[0] != `DSI_ID_VSS || link_b[0] != `DSI_ID_VSS)
			log_fail($sformatf("no VSS word %0d words after the previous one", FRAME_WORDS));
	endtask

	task automatic check_pixel_content();
		logic [HEIGHT-1:0] rows;
		logic [23:0] want_a;
		logic [23:0] want_b;
		int line;
		int word;
		int y;
		rows = '0;
		for (int i = 0; i < PIX_LINES; i++) begin
			rand_state = lcg_next(rand_state);
			rows[(rand_state >> 16) % HEIGHT] = 1'b1;
		end
		for (int pos = 0; pos < FRAME_WORDS; pos++) begin
			line = pos / LINE_WORDS;
			word = pos % LINE_WORDS;
			y = line - V_BACK;
			if (word == H_BLANK && y >= 0 && y < HEIGHT && rows[y]) begin
				for (int p = 0; p < 2; p++) begin
					want_a = expected_colour(p, y);
					want_b = expected_colour(HALF_WIDTH + p, y);
					// r, g, b in transmit order
					for (int c = 0; c < 3; c++) begin
						compare_byte("A", line, word, 3 * p + c, link_a[3 * p + c],
							want_a[23 - 8 * c -: 8]);
						compare_byte("B", line, word, 3 * p + c, link_b[3 * p + c],
							want_b[23 - 8 * c -: 8]);
					end
				end
			end
			next_cycle();
		end
	endtask

	//////////////////////////////
	// Run control

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles with %0d errors so far", cycle_count, err_count);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int total;
		i_rst_n = 1'b0;
		err_count = 0;
		cycle_count = 0;
		rand_state = 32'h3deb;
		repeat (8) @(posedge clk);
		#1 i_rst_n = 1'b1;
		fork
			check_power_sequence();
			check_idle_links();
		join
		find_first_vss();
		check_line_headers(1'b1);
		check_frame_repeat();
		check_line_headers(1'b0);
		check_frame_repeat();
		check_pixel_content();
		total = err_count + dsi_pattern_top_inst.checker_inst.failures;
		$display("Errors: %0d in checks, %0d in assertions", err_count,
			dsi_pattern_top_inst.checker_inst.failures);
		if (total == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== tests/dsi_pattern_checker.sv ====
`timescale 1ns/1ps

module dsi_pattern_checker (
	input logic               clk,
	input logic               i_rst_n,
	input logic               i_lcd_en_vcc,
	input logic               i_lcd_reset,
	input logic               i_lp_en,
	input logic               i_hs_en,
	input dsi_pkg::dsi_word_t i_link_a,
	input dsi_pkg::dsi_word_t i_link_b
);

	// Number of failed assertions so far
	int failures = 0;

	//////////////////////////////
	// Power sequencing

	// Panel reset only released with VCC up
	reset_after_vcc: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_lcd_reset |-> i_lcd_en_vcc)
		else begin
			failures++;
			$error("panel reset released while vcc is off");
		end

	// LP window and HS mode are exclusive
	lp_hs_exclusive: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_lp_en && i_hs_en))
		else begin
			failures++;
			$error("lp_en and hs_en high together");
		end

	// Once in HS mode the link stays there
	hs_holds: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_hs_en |=> i_hs_en)
		else begin
			failures++;
			$error("hs_en fell after rising");
		end

	//////////////////////////////
	// Link outputs

	links_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
		!i_hs_en |-> (i_link_a == '0 && i_link_b == '0))
		else begin
			failures++;
			$error("link data present before hs_en");
		end

endmodule

// ==== rtl/dsi_pattern_top.sv ====
`timescale 1ns/1ps
`include "dsi_macros.svh"

module dsi_pattern_top #(
	parameter int MS_CYCLES = `DSI_MS_CYCLES,
	parameter int HALF_WIDTH = `VID_HALF_WIDTH,
	parameter int HEIGHT = `VID_HEIGHT,
	parameter int V_BACK = `VID_V_BACK,
	parameter int V_TOTAL = `VID_V_TOTAL,
	parameter int H_BLANK = `VID_H_BLANK,
	parameter int LINE_WORDS = `VID_LINE_WORDS
) (
	input  logic               clk,
	input  logic               i_rst_n,
	output logic               o_lcd_en_vcc,
	output logic               o_lcd_en_vsp,
	output logic               o_lcd_en_vsn,
	output logic               o_lcd_reset,
	output logic               o_lp_en,
	output logic               o_hs_en,
	output dsi_pkg::dsi_word_t o_link_a,
	output dsi_pkg::dsi_word_t o_link_b
);

	logic                 video_en;
	logic [15:0]          word_idx;
	logic [15:0]          line_idx;
	logic                 first_frame;
	logic                 vsync;
	logic                 hsync;
	logic                 line_active;
	logic                 payload;
	logic                 pix_active;
	logic [2:0]           phase;
	dsi_pkg::pixel_quad_t left_quad;
	dsi_pkg::pixel_quad_t right_quad;

	//////////////////////////////
	// Panel bring-up and timing

	lcd_power_seq #(
		.MS_CYCLES(MS_CYCLES)
	) power_seq_inst (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.o_lcd_en_vcc(o_lcd_en_vcc),
		.o_lcd_en_vsp(o_lcd_en_vsp),
		.o_lcd_en_vsn(o_lcd_en_vsn),
		.o_lcd_reset(o_lcd_reset),
		.o_lp_en(o_lp_en),
		.o_hs_en(o_hs_en),
		.o_video_en(video_en)
	);

	video_timing #(
		.HALF_WIDTH(HALF_WIDTH),
		.HEIGHT(HEIGHT),
		.V_BACK(V_BACK),
		.V_TOTAL(V_TOTAL),
		.H_BLANK(H_BLANK),
		.LINE_WORDS(LINE_WORDS)
	) timing_inst (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_video_en(video_en),
		.o_word_idx(word_idx),
		.o_line_idx(line_idx),
		.o_first_frame(first_frame),
		.o_vsync(vsync),
		.o_hsync(hsync),
		.o_line_active(line_active),
		.o_payload(payload),
		.o_pix_active(pix_active),
		.o_phase(phase)
	);

	//////////////////////////////
	// Pattern and link framing

	smpte_pattern #(
		.HALF_WIDTH(HALF_WIDTH),
		.HEIGHT(HEIGHT)
	) pattern_inst (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_vsync(vsync),
		.i_hsync(hsync),
		.i_pix_active(pix_active),
		.i_phase(phase),
		.o_left(left_quad),
		.o_right(right_quad)
	);

	dsi_framer #(
		.HALF_WIDTH(HALF_WIDTH),
		.H_BLANK(H_BLANK)
	) framer_inst (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_video_en(video_en),
		.i_first_frame(first_frame),
		.i_line_active(line_active),
		.i_payload(payload),
		.i_word_idx(word_idx),
		.i_line_idx(line_idx),
		.i_phase(phase),
		.i_left(left_quad),
		.i_right(right_quad),
		.o_link_a(o_link_a),
		.o_link_b(o_link_b)
	);

endmodule

// ==== rtl/dsi_framer.sv ====
`timescale 1ns/1ps
`include "dsi_macros.svh"

module dsi_framer #(
	parameter int HALF_WIDTH = `VID_HALF_WIDTH,
	parameter int H_BLANK = `VID_H_BLANK
) (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_video_en,
	input  logic                 i_first_frame,
	input  logic                 i_line_active,
	input  logic                 i_payload,
	input  logic [15:0]          i_word_idx,
	input  logic [15:0]          i_line_idx,
	input  logic [2:0]           i_phase,
	input  dsi_pkg::pixel_quad_t i_left,
	input  dsi_pkg::pixel_quad_t i_right,
	output dsi_pkg::dsi_word_t   o_link_a,
	output dsi_pkg::dsi_word_t   o_link_b
);

	localparam int PAY_WORDS = HALF_WIDTH * 3 / 8;

	localparam logic [15:0] W_PRE0 = 16'(H_BLANK - 2);
	localparam logic [15:0] W_PRE1 = 16'(H_BLANK - 1);
	localparam logic [15:0] W_POST = 16'(H_BLANK + PAY_WORDS);
	localparam logic [15:0] W_DISP_ON = 16'd8;

	// Long packet word count in bytes
	localparam logic [15:0] WC_RGB = 16'(HALF_WIDTH * 3);

	// Header bits covered by each ECC parity bit, DSI section 9.3
	localparam logic [23:0] ECC_MASK [6] = '{
		24'hF12CB7, 24'hF2555B, 24'h749A6D,
		24'hB8E38E, 24'hDF03F0, 24'hEFFC00
	};

	//////////////////////////////
	// Packet helpers

	// Header of three bytes followed by its ECC byte
	function automatic logic [31:0] ecc(input logic [23:0] hdr);
		logic [23:0] d;
		logic [7:0] p;
		d = {hdr[7:0], hdr[15:8], hdr[23:16]};
		p = '0;
		for (int i = 0; i < 6; i++) begin
			p[i] = ^(d & ECC_MASK[i]);
		end
		return {hdr, p};
	endfunction

	// CRC-16 over the low len bytes, highest byte sent first, LSB first
	function automatic logic [15:0] crc16(input logic [47:0] din, input int len);
		logic [15:0] s;
		logic fb;
		s = 16'hffff;
		for (int i = 5; i >= 0; i--) begin
			if (i < len) begin
				for (int j = 0; j < 8; j++) begin
					fb = s[0] ^ din[i*8+j];
					s = (s >> 1) ^ (fb ? 16'h8408 : 16'h0000);
				end
			end
		end
		return {s[7:0], s[15:8]};
	endfunction

	// Big-endian build order to link byte order
	function automatic dsi_pkg::dsi_word_t swap8(input logic [63:0] din);
		dsi_pkg::dsi_word_t w;
		for (int i = 0; i < 8; i++) begin
			w[i] = din[63-8*i -: 8];
		end
		return w;
	endfunction

	// 2:3 packing of quads into link words
	function automatic dsi_pkg::dsi_word_t pack(input dsi_pkg::pixel_quad_t cur,
		input dsi_pkg::pixel_quad_t held, input logic [2:0] ph);
		logic [95:0] c;
		logic [95:0] h;
		c = cur;
		h = held;
		if (ph[0])
			return c[63:0];
		else if (ph[1])
			return {c[31:0], h[95:64]};
		return h[95:32];
	endfunction

	//////////////////////////////
	// Constant packets

	localparam dsi_pkg::dsi_word_t PKT_BLANK = swap8({ecc({`DSI_ID_BLANK, 8'h02, 8'h00}),
		16'h0000, crc16(48'h0, 2)});
	localparam dsi_pkg::dsi_word_t PKT_VSS = swap8({ecc({`DSI_ID_VSS, 16'h0000}),
		ecc({`DSI_ID_BLANK, 8'h06, 8'h00})});
	localparam dsi_pkg::dsi_word_t PKT_HSS = swap8({ecc({`DSI_ID_HSS, 16'h0000}),
		ecc({`DSI_ID_BLANK, 8'h06, 8'h00})});
	// Six byte blanking payload opened by the sync word
	localparam dsi_pkg::dsi_word_t PKT_POST_SHORT = swap8({48'h0, crc16(48'h0, 6)});
	// Display on, then sleep out
	localparam dsi_pkg::dsi_word_t PKT_DISP_ON = swap8({ecc({`DSI_ID_DCS_SHORT, 8'h29, 8'h00}),
		ecc({`DSI_ID_DCS_SHORT, 8'h11, 8'h00})});
	// Blanking pad split over two words, RGB24 header in the upper half of the second
	localparam dsi_pkg::dsi_word_t PKT_PRE_RGB0 = swap8({ecc({`DSI_ID_BLANK, 8'h06, 8'h00}),
		32'h0});
	localparam dsi_pkg::dsi_word_t PKT_PRE_RGB1 = swap8({16'h0, crc16(48'h0, 6),
		ecc({`DSI_ID_RGB24, WC_RGB[7:0], WC_RGB[15:8]})});
	// Video CRC left as zero, then an empty blanking packet
	localparam dsi_pkg::dsi_word_t PKT_POST_RGB = swap8({16'h0000,
		ecc({`DSI_ID_BLANK, 8'h00, 8'h00}), crc16(48'h0, 0)});

	dsi_pkg::pixel_quad_t held_l;
	dsi_pkg::pixel_quad_t held_r;

	always_ff @(posedge clk) begin
		held_l <= i_left;
		held_r <= i_right;
	end

	//////////////////////////////
	// Word selection

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_link_a <= '0;
			o_link_b <= '0;
		end else if (!i_video_en) begin
			o_link_a <= '0;
			o_link_b <= '0;
		end else if (i_word_idx == '0) begin
			o_link_a <= (i_line_idx == '0) ? PKT_VSS : PKT_HSS;
			o_link_b <= (i_line_idx == '0) ? PKT_VSS : PKT_HSS;
		end else if (i_word_idx == 16'd1) begin
			o_link_a <= PKT_POST_SHORT;
			o_link_b <= PKT_POST_SHORT;
		end else if (i_first_frame && i_line_idx == '0 && i_word_idx == W_DISP_ON) begin
			o_link_a <= PKT_DISP_ON;
			o_link_b <= PKT_DISP_ON;
		end else if (i_line_active && i_word_idx == W_PRE0) begin
			o_link_a <= PKT_PRE_RGB0;
			o_link_b <= PKT_PRE_RGB0;
		end else if (i_line_active && i_word_idx == W_PRE1) begin
			o_link_a <= PKT_PRE_RGB1;
			o_link_b <= PKT_PRE_RGB1;
		end else if (i_line_active && i_payload) begin
			o_link_a <= pack(i_left, held_l, i_phase);
			o_link_b <= pack(i_right, held_r, i_phase);
		end else if (i_line_active && i_word_idx == W_POST) begin
			o_link_a <= PKT_POST_RGB;
			o_link_b <= PKT_POST_RGB;
		end else begin
			o_link_a <= PKT_BLANK;
			o_link_b <= PKT_BLANK;
		end
	end

endmodule

// ==== rtl/smpte_pattern.sv ====
`timescale 1ns/1ps
`include "dsi_macros.svh"

module smpte_pattern #(
	parameter int HALF_WIDTH = `VID_HALF_WIDTH,
	parameter int HEIGHT = `VID_HEIGHT
) (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_vsync,
	input  logic                 i_hsync,
	input  logic                 i_pix_active,
	input  logic [2:0]           i_phase,
	output dsi_pkg::pixel_quad_t o_left,
	output dsi_pkg::pixel_quad_t o_right
);

	localparam int WIDTH = 2 * HALF_WIDTH;
	localparam int X_W = $clog2(WIDTH + 1);
	localparam int Y_W = $clog2(HEIGHT + 1);

	localparam logic [23:0] WHITE = 24'hffffff;

	// Upper bars left to right
	localparam logic [23:0] UPPER_BARS [7] = '{
		24'hc0c0c0, 24'hc0c000, 24'h00c0c0, 24'h00c000,
		24'hc000c0, 24'hc00000, 24'h0000c0
	};

	// Lower bars left to right
	localparam logic [23:0] LOWER_BARS [6] = '{
		24'h00214c, 24'hffffff, 24'h32006a,
		24'h1d1d1d, 24'h131313, 24'h090909
	};

	logic [X_W-1:0] col;
	logic [Y_W-1:0] row;
	logic           pix_d1;
	logic           act2;
	logic [X_W-1:0] x1;
	logic [X_W-1:0] x2;
	logic [Y_W-1:0] y1;
	logic [Y_W-1:0] y2;

	function automatic logic [23:0] colour_at(input int x, input int y);
		int bar;
		bar = 0;
		// Border square
		if (x == 0 || y == 0 || x == WIDTH - 1 || y == HEIGHT - 1) begin
			return WHITE;
		end
		// Diagonal cross
		if (x == y || x == HEIGHT - 1 - y) begin
			return WHITE;
		end
		if (y <= (HEIGHT * 3) / 4) begin
			for (int k = 1; k < 7; k++) begin
				if (x >= (WIDTH * k) / 7)
					bar = k;
			end
			return UPPER_BARS[bar];
		end
		for (int k = 1; k < 6; k++) begin
			if (x >= (WIDTH * k) / 6)
				bar = k;
		end
		return LOWER_BARS[bar];
	endfunction

	function automatic dsi_pkg::rgb_t to_rgb(input logic [23:0] hex);
		dsi_pkg::rgb_t c;
		c.r = hex[23:16];
		c.g = hex[15:8];
		c.b = hex[7:0];
		return c;
	endfunction

	//////////////////////////////
	// Coordinate tracking

	// x steps by four pixels on phase 0 and 1, phase 2 reuses the held quad
	// Row advances when the pixel window of a line closes
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col <= '0;
			row <= '0;
			pix_d1 <= 1'b0;
			act2 <= 1'b0;
		end else begin
			pix_d1 <= i_pix_active;
			act2 <= pix_d1;
			if (i_hsync)
				col <= '0;
			else if (i_pix_active && |i_phase[1:0])
				col <= col + X_W'(4);
			if (i_vsync)
				row <= '0;
			else if (pix_d1 && !i_pix_active)
				row <= row + 1'b1;
		end
	end

	// Two coordinate stages plus the colour stage make the three cycle lead
	always_ff @(posedge clk) begin
		x1 <= col;
		y1 <= row;
		x2 <= x1;
		y2 <= y1;
	end

	//////////////////////////////
	// Colour selection

	// Right half is the same picture shifted by half the panel
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (act2) begin
				o_left[i] <= to_rgb(colour_at(int'(x2) + i, int'(y2)));
				o_right[i] <= to_rgb(colour_at(int'(x2) + HALF_WIDTH + i, int'(y2)));
			end else begin
				o_left[i] <= '0;
				o_right[i] <= '0;
			end
		end
	end

endmodule

// ==== rtl/video_timing.sv ====
`timescale 1ns/1ps
`include "dsi_macros.svh"

module video_timing #(
	parameter int HALF_WIDTH = `VID_HALF_WIDTH,
	parameter int HEIGHT = `VID_HEIGHT,
	parameter int V_BACK = `VID_V_BACK,
	parameter int V_TOTAL = `VID_V_TOTAL,
	parameter int H_BLANK = `VID_H_BLANK,
	parameter int LINE_WORDS = `VID_LINE_WORDS
) (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic        i_video_en,
	output logic [15:0] o_word_idx,
	output logic [15:0] o_line_idx,
	output logic        o_first_frame,
	output logic        o_vsync,
	output logic        o_hsync,
	output logic        o_line_active,
	output logic        o_payload,
	output logic        o_pix_active,
	output logic [2:0]  o_phase
);

	localparam int PAY_WORDS = HALF_WIDTH * 3 / 8;
	localparam int PIX_LAT = `VID_PIX_LAT;

	localparam logic [15:0] WORD_LAST = 16'(LINE_WORDS - 1);
	localparam logic [15:0] LINE_LAST = 16'(V_TOTAL - 1);
	localparam logic [15:0] ACT_FIRST = 16'(V_BACK);
	localparam logic [15:0] ACT_END = 16'(V_BACK + HEIGHT);
	localparam logic [15:0] PAY_FIRST = 16'(H_BLANK);
	localparam logic [15:0] PAY_END = 16'(H_BLANK + PAY_WORDS);
	localparam logic [15:0] PIX_FIRST = 16'(H_BLANK - PIX_LAT);
	localparam logic [15:0] PIX_END = 16'(H_BLANK + PAY_WORDS - PIX_LAT);

	// Phase loaded at word 0, chosen so the first payload word is on bit 0
	// For H_BLANK a multiple of three this is simply bit 0
	localparam logic [2:0] PH_WORD0 = 3'b001 << ((3 - H_BLANK % 3) % 3);

	logic line_end;
	logic frame_end;

	assign line_end = (o_word_idx == WORD_LAST);
	assign frame_end = line_end && (o_line_idx == LINE_LAST);

	//////////////////////////////
	// Word and line counters

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_word_idx <= '0;
			o_line_idx <= '0;
			o_first_frame <= 1'b1;
			o_phase <= PH_WORD0;
		end else if (!i_video_en) begin
			o_word_idx <= '0;
			o_line_idx <= '0;
			o_phase <= PH_WORD0;
		end else if (line_end) begin
			o_word_idx <= '0;
			o_phase <= PH_WORD0;
			if (frame_end) begin
				o_line_idx <= '0;
				o_first_frame <= 1'b0;
			end else begin
				o_line_idx <= o_line_idx + 16'd1;
			end
		end else begin
			o_word_idx <= o_word_idx + 16'd1;
			o_phase <= {o_phase[1:0], o_phase[2]};
		end
	end

	//////////////////////////////
	// Strobes

	assign o_vsync = i_video_en && (o_word_idx == '0) && (o_line_idx == '0);
	assign o_hsync = i_video_en && (o_word_idx == '0);
	assign o_line_active = i_video_en && (o_line_idx >= ACT_FIRST) && (o_line_idx < ACT_END);
	assign o_payload = i_video_en && (o_word_idx >= PAY_FIRST) && (o_word_idx < PAY_END);

	// Early copy of the payload window, gives the pattern its pipeline time
	assign o_pix_active = o_line_active && (o_word_idx >= PIX_FIRST) && (o_word_idx < PIX_END);

endmodule

// ==== rtl/lcd_power_seq.sv ====
`timescale 1ns/1ps
`include "dsi_macros.svh"

module lcd_power_seq #(
	parameter int MS_CYCLES = `DSI_MS_CYCLES
) (
	input  logic clk,
	input  logic i_rst_n,
	output logic o_lcd_en_vcc,
	output logic o_lcd_en_vsp,
	output logic o_lcd_en_vsn,
	output logic o_lcd_reset,
	output logic o_lp_en,
	output logic o_hs_en,
	output logic o_video_en
);

	localparam int CNT_MAX = 26 * MS_CYCLES;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	// Thresholds in cycles
	localparam logic [CNT_W-1:0] T_VCC = CNT_W'(1 * MS_CYCLES);
	localparam logic [CNT_W-1:0] T_VSP = CNT_W'(2 * MS_CYCLES);
	localparam logic [CNT_W-1:0] T_VSN = CNT_W'(3 * MS_CYCLES);
	localparam logic [CNT_W-1:0] T_RST = CNT_W'(6 * MS_CYCLES);
	localparam logic [CNT_W-1:0] T_HS = CNT_W'(CNT_MAX);

	logic [CNT_W-1:0] count;

	// Time since reset, stops once high speed is reached
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count <= '0;
		end else if (count != T_HS) begin
			count <= count + 1'b1;
		end
	end

	// Supplies first, then panel reset release, LP window and HS
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_lcd_en_vcc <= 1'b0;
			o_lcd_en_vsp <= 1'b0;
			o_lcd_en_vsn <= 1'b0;
			o_lcd_reset <= 1'b0;
			o_lp_en <= 1'b0;
			o_hs_en <= 1'b0;
		end else begin
			o_lcd_en_vcc <= count > T_VCC;
			o_lcd_en_vsp <= count > T_VSP;
			o_lcd_en_vsn <= count > T_VSN;
			o_lcd_reset <= count > T_RST;
			o_lp_en <= (count > T_VSN) && (count < T_HS);
			o_hs_en <= count >= T_HS;
		end
	end

	// Video follows HS mode directly
	assign o_video_en = o_hs_en;

endmodule

// ==== rtl/dsi_pkg.sv ====
package dsi_pkg;

	// One RGB24 pixel
	// Red sits in the low byte so it goes out first on the link
	typedef struct packed {
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} rgb_t;

	// Four neighbouring pixels of one half of the panel
	// Pixel 0 is the leftmost and lives in the low bits
	typedef rgb_t [3:0] pixel_quad_t;

	// One cycle of data for a four-lane link
	// Byte 0 is transmitted first
	typedef logic [7:0][7:0] dsi_word_t;

endpackage

// ==== include/dsi_macros.svh ====
`ifndef DSI_MACROS_SVH
`define DSI_MACROS_SVH

// Byte clock cycles in one millisecond at 62.5 MHz
`define DSI_MS_CYCLES 62500

//////////////////////////////
// Panel geometry

// Pixels carried by each of the two links
`define VID_HALF_WIDTH 800
`define VID_HEIGHT 1600

// Vertical timing in lines
`define VID_V_BACK 150
`define VID_V_TOTAL 1779

// Horizontal timing in 64-bit link words
`define VID_H_BLANK 45
`define VID_LINE_WORDS 390

// Pixel strobe lead over the payload, in cycles
`define VID_PIX_LAT 3

//////////////////////////////
// DSI data identifiers

`define DSI_ID_VSS 8'h01
`define DSI_ID_HSS 8'h21
`define DSI_ID_BLANK 8'h19
`define DSI_ID_NULL 8'h09
`define DSI_ID_DCS_SHORT 8'h05
`define DSI_ID_RGB24 8'h3E

`endif
